//--- src/apbSysPkg.sv
package apbSysPkg;

    localparam int dataWidth = 32;

    // Slot field of the APB address
    localparam int slotMsb = 23;
    localparam int slotLsb = 20;
    localparam int slotNum = 16;

    // Byte offsets inside one timer slot
    localparam logic [7:0] regCount     = 8'h00;
    localparam logic [7:0] regPrescale  = 8'h04;
    localparam logic [7:0] regCompare   = 8'h08;
    localparam logic [7:0] regControl   = 8'h0C;
    localparam logic [7:0] regStatus    = 8'h10;
    localparam logic [7:0] regIrqEnable = 8'h14;

    typedef struct packed {
        logic [dataWidth-2-slotMsb:0] upper;
        logic [slotMsb-slotLsb:0]     slot;
        logic [slotLsb-9:0]           spare;
        logic [7:0]                   offset;
    } apbAddrFields_s;

    // Flat word for the bridge, fields for the decoders
    typedef union packed {
        logic [dataWidth-1:0] word;
        apbAddrFields_s       fields;
    } apbAddr_u;

    typedef enum logic [1:0] {
        stIdle   = 2'd0,
        stSetup  = 2'd1,
        stAccess = 2'd2
    } bridgeState_e;

endpackage

//--- src/ahbApbBridge.sv
module ahbApbBridge
    import apbSysPkg::*;
(
    input  logic                 HCLK,
    input  logic                 HRESETn,
    input  logic [dataWidth-1:0] haddr_i,
    input  logic [1:0]           htrans_i,
    input  logic                 hwrite_i,
    input  logic [dataWidth-1:0] hwdata_i,
    input  logic                 hsel_i,
    input  logic                 hready_i,
    input  logic [dataWidth-1:0] prdata_i,
    input  logic                 pready_i,
    output logic [dataWidth-1:0] hrdata_o,
    output logic                 hreadyout_o,
    output logic [dataWidth-1:0] paddr_o,
    output logic                 pwrite_o,
    output logic [dataWidth-1:0] pwdata_o,
    output logic                 psel_o,
    output logic                 penable_o
);

    bridgeState_e         state;
    bridgeState_e         stateNext;
    apbAddr_u             addrQ;
    logic                 writeQ;
    logic [dataWidth-1:0] wdataQ;
    logic [dataWidth-1:0] rdataQ;
    logic                 accept;

    // NONSEQ or SEQ to this slave while no transfer is pending
    assign accept = hsel_i && hready_i && htrans_i[1] && (state == stIdle);

    always_comb begin
        stateNext = state;
        case (state)
            stIdle:   if (accept) stateNext = stSetup;
            stSetup:  stateNext = stAccess;
            stAccess: if (pready_i) stateNext = stIdle;
            default:  stateNext = stIdle;
        endcase
    end

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            state <= stIdle;
        end else begin
            state <= stateNext;
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            addrQ.word <= haddr_i;
            writeQ     <= hwrite_i;
        end
        // AHB data phase lines up with APB setup
        if (state == stSetup && writeQ) begin
            wdataQ <= hwdata_i;
        end
        if (state == stAccess && pready_i && !writeQ) begin
            rdataQ <= prdata_i;
        end
    end

    assign paddr_o     = addrQ.word;
    assign pwrite_o    = writeQ;
    assign pwdata_o    = wdataQ;
    assign psel_o      = (state != stIdle);
    assign penable_o   = (state == stAccess);
    assign hreadyout_o = (state == stIdle);
    assign hrdata_o    = rdataQ;

    // Access phase always follows exactly one setup cycle
    penableAfterSetup: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        $rose(penable_o) |-> $past(psel_o && !penable_o)
    );

endmodule

//--- src/apbSlotMux.sv
module apbSlotMux
    import apbSysPkg::*;
#(
    parameter int slotUsed = 2
) (
    input  apbAddr_u                            paddr_i,
    input  logic                                psel_i,
    input  logic [slotUsed-1:0][dataWidth-1:0]  prdata_i,
    input  logic [slotUsed-1:0]                 pready_i,
    output logic [slotUsed-1:0]                 slotSel_o,
    output logic [dataWidth-1:0]                prdata_o,
    output logic                                pready_o
);

    logic [slotNum-1:0] slotDec;

    // Full decode of the slot field
    always_comb begin
        slotDec = '0;
        slotDec[paddr_i.fields.slot] = psel_i;
    end

    assign slotSel_o = slotDec[slotUsed-1:0];

    // Empty slots read zero and never stall
    always_comb begin
        prdata_o = '0;
        pready_o = 1'b1;
        for (int i = 0; i < slotUsed; i++) begin
            if (paddr_i.fields.slot == i) begin
                prdata_o = prdata_i[i];
                pready_o = pready_i[i];
            end
        end
    end

    // At most one slave selected
    always_comb begin
        slotSelCheck: assert ($onehot0(slotSel_o));
    end

endmodule

//--- src/timerRegs.sv
module timerRegs
    import apbSysPkg::*;
(
    input  logic                 HCLK,
    input  logic                 HRESETn,
    input  apbAddr_u             paddr_i,
    input  logic                 pwrite_i,
    input  logic [dataWidth-1:0] pwdata_i,
    input  logic                 psel_i,
    input  logic                 penable_i,
    input  logic [dataWidth-1:0] count_i,
    input  logic                 overflow_i,
    output logic [dataWidth-1:0] prdata_o,
    output logic                 pready_o,
    output logic [dataWidth-1:0] prescale_o,
    output logic [dataWidth-1:0] compare_o,
    output logic                 enable_o,
    output logic                 ovClear_o,
    output logic                 irq_o
);

    logic wrEn;
    logic irqEn;

    // Writes land at the end of the access phase
    assign wrEn     = psel_i && penable_i && pwrite_i;
    assign pready_o = 1'b1;

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            prescale_o <= '0;
            compare_o  <= '0;
            enable_o   <= 1'b0;
            irqEn      <= 1'b0;
        end else if (wrEn) begin
            case (paddr_i.fields.offset)
                regPrescale:  prescale_o <= pwdata_i;
                regCompare:   compare_o  <= pwdata_i;
                regControl:   enable_o   <= pwdata_i[0];
                regIrqEnable: irqEn      <= pwdata_i[0];
                default:      ;
            endcase
        end
    end

    // Write one to clear
    assign ovClear_o = wrEn && (paddr_i.fields.offset == regStatus) && pwdata_i[0];

    always_comb begin
        prdata_o = '0;
        case (paddr_i.fields.offset)
            regCount:     prdata_o    = count_i;
            regPrescale:  prdata_o    = prescale_o;
            regCompare:   prdata_o    = compare_o;
            regControl:   prdata_o[0] = enable_o;
            regStatus:    prdata_o[0] = overflow_i;
            regIrqEnable: prdata_o[0] = irqEn;
            default:      ;
        endcase
    end

    assign irq_o = overflow_i && irqEn;

endmodule

//--- src/timerCounter.sv
module timerCounter
    import apbSysPkg::*;
(
    input  logic                 HCLK,
    input  logic                 HRESETn,
    input  logic [dataWidth-1:0] prescale_i,
    input  logic [dataWidth-1:0] compare_i,
    input  logic                 enable_i,
    input  logic                 ovClear_i,
    output logic [dataWidth-1:0] count_o,
    output logic                 overflow_o
);

    logic [dataWidth-1:0] preCnt;
    logic                 step;
    logic                 wrap;

    // One step every prescale+1 enabled cycles
    assign step = enable_i && (preCnt >= prescale_i);
    assign wrap = step && (count_o >= compare_i);

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            preCnt  <= '0;
            count_o <= '0;
        end else if (!enable_i) begin
            preCnt <= '0;
        end else if (step) begin
            preCnt  <= '0;
            count_o <= wrap ? '0 : count_o + 1'b1;
        end else begin
            preCnt <= preCnt + 1'b1;
        end
    end

    // New overflow beats a clear in the same cycle
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            overflow_o <= 1'b0;
        end else if (wrap) begin
            overflow_o <= 1'b1;
        end else if (ovClear_i) begin
            overflow_o <= 1'b0;
        end
    end

    // Disabled timer stays frozen
    idleWhenDisabled: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        !enable_i |=> (preCnt == '0) && $stable(count_o)
    );

endmodule

//--- src/apbTimerSys.sv
module apbTimerSys
    import apbSysPkg::*;
#(
    parameter int timerCount = 2
) (
    input  logic                  HCLK,
    input  logic                  HRESETn,
    input  logic [dataWidth-1:0]  haddr_i,
    input  logic [1:0]            htrans_i,
    input  logic                  hwrite_i,
    input  logic [dataWidth-1:0]  hwdata_i,
    input  logic                  hsel_i,
    input  logic                  hready_i,
    output logic [dataWidth-1:0]  hrdata_o,
    output logic                  hreadyout_o,
    output logic [timerCount-1:0] irq_o
);

    logic [dataWidth-1:0]                  paddr;
    logic                                  pwrite;
    logic [dataWidth-1:0]                  pwdata;
    logic                                  psel;
    logic                                  penable;
    logic [dataWidth-1:0]                  prdata;
    logic                                  pready;
    logic [timerCount-1:0]                 slotSel;
    logic [timerCount-1:0][dataWidth-1:0]  slotRdata;
    logic [timerCount-1:0]                 slotReady;

    ahbApbBridge u_bridge (
        .HCLK        (HCLK),
        .HRESETn     (HRESETn),
        .haddr_i     (haddr_i),
        .htrans_i    (htrans_i),
        .hwrite_i    (hwrite_i),
        .hwdata_i    (hwdata_i),
        .hsel_i      (hsel_i),
        .hready_i    (hready_i),
        .prdata_i    (prdata),
        .pready_i    (pready),
        .hrdata_o    (hrdata_o),
        .hreadyout_o (hreadyout_o),
        .paddr_o     (paddr),
        .pwrite_o    (pwrite),
        .pwdata_o    (pwdata),
        .psel_o      (psel),
        .penable_o   (penable)
    );

    apbSlotMux #(
        .slotUsed (timerCount)
    ) u_slotMux (
        .paddr_i   (paddr),
        .psel_i    (psel),
        .prdata_i  (slotRdata),
        .pready_i  (slotReady),
        .slotSel_o (slotSel),
        .prdata_o  (prdata),
        .pready_o  (pready)
    );

    // Timer n sits in slot n
    for (genvar n = 0; n < timerCount; n++) begin : g_timer
        logic [dataWidth-1:0] prescale;
        logic [dataWidth-1:0] compare;
        logic                 enable;
        logic                 ovClear;
        logic [dataWidth-1:0] count;
        logic                 overflow;

        timerRegs u_regs (
            .HCLK       (HCLK),
            .HRESETn    (HRESETn),
            .paddr_i    (paddr),
            .pwrite_i   (pwrite),
            .pwdata_i   (pwdata),
            .psel_i     (slotSel[n]),
            .penable_i  (penable),
            .count_i    (count),
            .overflow_i (overflow),
            .prdata_o   (slotRdata[n]),
            .pready_o   (slotReady[n]),
            .prescale_o (prescale),
            .compare_o  (compare),
            .enable_o   (enable),
            .ovClear_o  (ovClear),
            .irq_o      (irq_o[n])
        );

        timerCounter u_counter (
            .HCLK       (HCLK),
            .HRESETn    (HRESETn),
            .prescale_i (prescale),
            .compare_i  (compare),
            .enable_i   (enable),
            .ovClear_i  (ovClear),
            .count_o    (count),
            .overflow_o (overflow)
        );
    end

endmodule

//--- testbench/tbApbTimerSys.sv
module tbApbTimerSys
    import apbSysPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          clkPeriod   = 40;
    localparam int          driveDelay  = 2;
    localparam int          resetCycles = 2;
    localparam int          numTimers   = 2;
    localparam int          pollLimit   = 40;
    localparam logic [31:0] lfsrSeed    = 32'd38;
    localparam logic [31:0] lfsrTaps    = 32'hB4BCD35C;

    // Cycle budget of each test
    localparam int lenReset    = 60;
    localparam int lenReadback = 120;
    localparam int lenEmpty    = 300;
    localparam int lenOverflow = 250;
    localparam int lenIrq      = 60;
    localparam int totalCycles = resetCycles + lenReset + lenReadback + lenEmpty
                                 + lenOverflow + lenIrq;

    logic                 HCLK;
    logic                 HRESETn;
    logic [31:0]          haddr;
    logic [1:0]           htrans;
    logic                 hwrite;
    logic [31:0]          hwdata;
    logic                 hsel;
    logic                 hready;
    logic [31:0]          hrdata;
    logic                 hreadyout;
    logic [numTimers-1:0] irq;

    logic [31:0] shadowPrescale [numTimers];
    logic [31:0] shadowCompare  [numTimers];
    logic [31:0] shadowControl  [numTimers];
    logic [31:0] shadowIrqEn    [numTimers];
    logic [31:0] lfsrState;
    logic [31:0] rdata;
    string       testName;
    int          errorCount;
    int          errorsAtStart;
    int          testsRun;
    int          testsFailed;
    int          polls;

    apbTimerSys u_dut (
        .HCLK        (HCLK),
        .HRESETn     (HRESETn),
        .haddr_i     (haddr),
        .htrans_i    (htrans),
        .hwrite_i    (hwrite),
        .hwdata_i    (hwdata),
        .hsel_i      (hsel),
        .hready_i    (hready),
        .hrdata_o    (hrdata),
        .hreadyout_o (hreadyout),
        .irq_o       (irq)
    );

    initial begin
        HCLK = 1'b0;
        forever #(clkPeriod / 2) HCLK = ~HCLK;
    end

    initial begin
        #(totalCycles * clkPeriod + 20 * clkPeriod);
        $display("timeout: the tests did not finish within %0d cycles", totalCycles);
        $display("FAIL: see errors above");
        $finish;
    end

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ lfsrTaps) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            r = {r[30:0], lfsrState[0]};
        end
        return r;
    endfunction

    // Count and status are live, so only the configuration registers are modelled
    function automatic logic [31:0] expectRead(input int slot, input logic [7:0] offset);
        if (slot >= numTimers) begin
            return '0;
        end
        case (offset)
            regPrescale:  return shadowPrescale[slot];
            regCompare:   return shadowCompare[slot];
            regControl:   return {31'b0, shadowControl[slot][0]};
            regIrqEnable: return {31'b0, shadowIrqEn[slot][0]};
            default:      return '0;
        endcase
    endfunction

    function automatic logic [31:0] addrOf(input int slot, input logic [7:0] offset);
        return (32'(slot) << slotLsb) | 32'(offset);
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            errorCount++;
            $display("error %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic nextCycle();
        @(posedge HCLK);
        #driveDelay;
    endtask

    task automatic waitReady();
        while (!hreadyout) begin
            nextCycle();
        end
    endtask

    task automatic ahbTransfer(input logic [31:0] addr, input logic write,
                               input logic [31:0] data);
        waitReady();
        haddr  = addr;
        hwrite = write;
        htrans = 2'b10;
        hsel   = 1'b1;
        nextCycle();
        // Data phase
        htrans = 2'b00;
        hsel   = 1'b0;
        hwdata = data;
        checkValue($sformatf("%s hreadyout in setup", testName), 32'h0, 32'(hreadyout));
        nextCycle();
        checkValue($sformatf("%s hreadyout in access", testName), 32'h0, 32'(hreadyout));
        waitReady();
    endtask

    task automatic ahbWrite(input logic [31:0] addr, input logic [31:0] data);
        ahbTransfer(addr, 1'b1, data);
    endtask

    task automatic ahbRead(input logic [31:0] addr, output logic [31:0] data);
        ahbTransfer(addr, 1'b0, '0);
        data = hrdata;
    endtask

    task automatic writeReg(input int slot, input logic [7:0] offset, input logic [31:0] data);
        ahbWrite(addrOf(slot, offset), data);
        if (slot < numTimers) begin
            case (offset)
                regPrescale:  shadowPrescale[slot] = data;
                regCompare:   shadowCompare[slot]  = data;
                regControl:   shadowControl[slot]  = data;
                regIrqEnable: shadowIrqEn[slot]    = data;
                default:      ;
            endcase
        end
    endtask

    task automatic readCheck(input int slot, input logic [7:0] offset);
        logic [31:0] data;
        ahbRead(addrOf(slot, offset), data);
        checkValue($sformatf("%s slot %0d offset 0x%02h", testName, slot, offset),
                   expectRead(slot, offset), data);
    endtask

    task automatic startTest(input string name);
        testName      = name;
        errorsAtStart = errorCount;
    endtask

    task automatic endTest();
        testsRun++;
        if (errorCount != errorsAtStart) begin
            testsFailed++;
            $display("test %s: failed", testName);
        end else begin
            $display("test %s: passed", testName);
        end
    endtask

    initial begin
        HRESETn   = 1'b0;
        haddr     = '0;
        htrans    = 2'b00;
        hwrite    = 1'b0;
        hwdata    = '0;
        hsel      = 1'b0;
        hready    = 1'b1;
        lfsrState = lfsrSeed;
        for (int s = 0; s < numTimers; s++) begin
            shadowPrescale[s] = '0;
            shadowCompare[s]  = '0;
            shadowControl[s]  = '0;
            shadowIrqEn[s]    = '0;
        end
        repeat (resetCycles) @(posedge HCLK);
        #driveDelay HRESETn = 1'b1;
        nextCycle();

        startTest("reset");
        checkValue("reset hreadyout", 32'h1, 32'(hreadyout));
        for (int s = 0; s < numTimers; s++) begin
            for (int r = 0; r < 6; r++) begin
                readCheck(s, 8'(4 * r));
            end
        end
        checkValue("reset irq", '0, 32'(irq));
        endTest();

        // Both slots written before either is read back
        startTest("readback");
        for (int s = 0; s < numTimers; s++) begin
            writeReg(s, regPrescale, randomBits(32));
            writeReg(s, regCompare, randomBits(32));
            writeReg(s, regControl, randomBits(32));
            writeReg(s, regIrqEnable, randomBits(32));
        end
        for (int s = 0; s < numTimers; s++) begin
            readCheck(s, regPrescale);
            readCheck(s, regCompare);
            readCheck(s, regControl);
            readCheck(s, regIrqEnable);
        end
        endTest();

        startTest("empty slots");
        for (int s = numTimers; s < slotNum; s++) begin
            writeReg(s, regPrescale, randomBits(32));
            writeReg(s, regCompare, randomBits(32));
            writeReg(s, regControl, randomBits(1));
            writeReg(s, regIrqEnable, randomBits(1));
            readCheck(s, regPrescale);
            readCheck(s, regIrqEnable);
        end
        for (int s = 0; s < numTimers; s++) begin
            readCheck(s, regPrescale);
            readCheck(s, regCompare);
            readCheck(s, regControl);
            readCheck(s, regIrqEnable);
        end
        endTest();

        startTest("overflow");
        for (int s = 0; s < numTimers; s++) begin
            writeReg(s, regControl, 32'd0);
            writeReg(s, regStatus, 32'd1);
            writeReg(s, regIrqEnable, 32'd0);
        end
        writeReg(0, regPrescale, 32'd0);
        writeReg(0, regCompare, 32'd3);
        writeReg(0, regIrqEnable, 32'd1);
        writeReg(0, regControl, 32'd1);
        polls = 0;
        rdata = '0;
        while (!rdata[0] && polls < pollLimit) begin
            ahbRead(addrOf(0, regStatus), rdata);
            polls++;
        end
        if (!rdata[0]) begin
            errorCount++;
            $display("timer 0 never reported overflow after %0d status polls", polls);
        end
        writeReg(0, regControl, 32'd0);
        ahbRead(addrOf(0, regCount), rdata);
        if (rdata > shadowCompare[0]) begin
            errorCount++;
            $display("timer 0 count %0d is above its compare value %0d", rdata,
                     shadowCompare[0]);
        end
        endTest();

        startTest("irq");
        checkValue("irq raised", 32'h1, 32'(irq));
        writeReg(0, regIrqEnable, 32'd0);
        checkValue("irq masked", 32'h0, 32'(irq));
        ahbRead(addrOf(0, regStatus), rdata);
        checkValue("irq status kept", 32'h1, rdata);
        writeReg(0, regIrqEnable, 32'd1);
        checkValue("irq unmasked", 32'h1, 32'(irq));
        writeReg(0, regStatus, 32'd1);
        ahbRead(addrOf(0, regStatus), rdata);
        checkValue("irq status cleared", 32'h0, rdata);
        checkValue("irq cleared", 32'h0, 32'(irq));
        endTest();

        $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- sources.f
src/apbSysPkg.sv
src/ahbApbBridge.sv
src/apbSlotMux.sv
src/timerRegs.sv
src/timerCounter.sv
src/apbTimerSys.sv
testbench/tbApbTimerSys.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbApbTimerSys
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
